// ==== list.f ====
+incdir+include
hdl/csr_pkg.sv
hdl/csr_decode.sv
hdl/csr_execute.sv
hdl/csr_file.sv
hdl/csr_result.sv
hdl/csr_unit.sv
verif/csr_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

# Build the simulator from the file list
verilator --binary --timing --timescale 1ns/100ps \
    -f list.f \
    --top-module csr_unit_tb \
    --Mdir "$build_dir" \
    -o csr_unit_sim
if [ $? -ne 0 ]; then
    echo "ERROR: Verilator build failed"
    exit 1
fi

"./$build_dir/csr_unit_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "ERROR: simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Testbench passed" "$log_file"; then
    echo "RESULT: PASS"
    exit 0
else
    echo "RESULT: FAIL"
    exit 1
fi

// ==== verif/csr_unit_tb.sv ====
`timescale 1ns/100ps
`include "csr_defines.svh"

module csr_unit_tb;

    import csr_pkg::*;

    localparam int num_random = 400;
    // Reset sweep, three fixed-register writes, random run, final sweep
    localparam int num_instr = 14 + 3 + num_random + 14;
    localparam int cycle_limit = num_instr + 3 + 20;
    localparam logic [31:0] mret_word = 32'h3020_0073;
    localparam logic [6:0] opcode_system = 7'b1110011;

    logic clk = 1'b0;
    logic rst_n;
    logic instr_valid;
    logic [31:0] instr;
    logic [`CSR_XLEN-1:0] rs1_data;
    logic rd_wr_en;
    logic [4:0] rd_addr;
    logic [`CSR_XLEN-1:0] rd_data;
    logic illegal_instr;
    logic mret_valid;
    logic [`CSR_XLEN-1:0] mret_pc;

    logic [31:0] rng_state;
    int cycle_count = 0;
    int instr_count = 0;
    logic [11:0] addr_list [14];
    logic [11:0] last_addr;
    logic [`CSR_XLEN-1:0] csr_model [4096];

    // Expected outputs of the instruction issued one cycle earlier
    logic exp_rd_wr_en;
    logic exp_illegal;
    logic exp_mret;
    logic exp_read_ok;
    logic [4:0] exp_rd_addr;
    logic [`CSR_XLEN-1:0] exp_rd_data;
    logic [`CSR_XLEN-1:0] exp_mret_pc;

    csr_unit dut_i (
        .clk(clk),
        .rst_n(rst_n),
        .instr_valid(instr_valid),
        .instr(instr),
        .rs1_data(rs1_data),
        .rd_wr_en(rd_wr_en),
        .rd_addr(rd_addr),
        .rd_data(rd_data),
        .illegal_instr(illegal_instr),
        .mret_valid(mret_valid),
        .mret_pc(mret_pc)
    );

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("Timeout after %0d cycles, the instruction sequence did not finish",
                     cycle_count);
            $display("Testbench failed");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Upper bits of the LCG are the better ones
    function automatic int rand_below(input int n);
        return int'((next_random() >> 8) % n);
    endfunction

    function automatic logic is_implemented(input logic [11:0] addr);
        logic found;
        found = 1'b0;
        for (int i = 0; i < 14; i++)
        begin
            if (addr_list[4'(i)] == addr)
                found = 1'b1;
        end
        return found;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Field masks of the writable registers
    task automatic write_model(input logic [11:0] addr, input logic [31:0] value);
        case (addr)
            csr_mstatus: csr_model[addr] = 32'h0000_1800 | (value & 32'h0000_0088);
            csr_mie: csr_model[addr] = value & `CSR_MIE_MASK;
            csr_mip: csr_model[addr] = value & `CSR_MIP_MASK;
            csr_mepc: csr_model[addr] = {value[31:2], 2'b00};
            csr_mscratch, csr_mcause, csr_mtval: csr_model[addr] = value;
            // Information registers, misa, mtvec and mcounteren stay fixed
            default: ;
        endcase
    endtask

    task automatic predict(input logic valid, input logic [31:0] word, input logic [31:0] data);
        logic [2:0] f3;
        logic [4:0] src;
        logic [11:0] addr;
        logic [31:0] operand;
        logic [31:0] old_val;
        logic intent;
        f3 = word[14:12];
        src = word[19:15];
        addr = word[31:20];
        operand = f3[2] ? {27'd0, src} : data;
        intent = (f3[1:0] == 2'b01) || (src != 5'd0);
        exp_read_ok = is_implemented(addr);
        old_val = exp_read_ok ? csr_model[addr] : '0;
        exp_rd_addr = word[11:7];
        exp_rd_data = old_val;
        exp_mret_pc = csr_model[csr_mepc];
        exp_mret = valid && (word == mret_word);
        exp_illegal = 1'b0;
        exp_rd_wr_en = 1'b0;
        if (!valid || word[6:0] != opcode_system)
            exp_read_ok = 1'b0;
        else if (exp_mret)
        begin
            // MIE takes MPIE, MPIE set, MPP stays machine
            csr_model[csr_mstatus] = 32'h0000_1880 | (csr_model[csr_mstatus][7] ? 32'h8 : 32'h0);
            exp_read_ok = 1'b0;
        end
        else if (f3 == 3'b000 || f3 == 3'b100 || (intent && addr[11:10] == 2'b11) ||
                 !exp_read_ok)
        begin
            exp_illegal = 1'b1;
            exp_read_ok = 1'b0;
        end
        else
        begin
            exp_rd_wr_en = word[11:7] != 5'd0;
            if (intent)
            begin
                case (f3[1:0])
                    2'b01: write_model(addr, operand);
                    2'b10: write_model(addr, old_val | operand);
                    default: write_model(addr, old_val & ~operand);
                endcase
            end
        end
    endtask

    task automatic check_outputs();
        string tag;
        tag = $sformatf("instr %0d", instr_count);
        check_value({tag, " rd_wr_en"}, {31'd0, exp_rd_wr_en}, {31'd0, rd_wr_en});
        check_value({tag, " illegal_instr"}, {31'd0, exp_illegal}, {31'd0, illegal_instr});
        check_value({tag, " mret_valid"}, {31'd0, exp_mret}, {31'd0, mret_valid});
        if (exp_read_ok)
            check_value({tag, " rd_data"}, exp_rd_data, rd_data);
        if (exp_rd_wr_en)
            check_value({tag, " rd_addr"}, {27'd0, exp_rd_addr}, {27'd0, rd_addr});
        if (exp_mret)
            check_value({tag, " mret_pc"}, exp_mret_pc, mret_pc);
    endtask

    // Called on a falling edge, returns on the next one
    task automatic issue(input logic valid, input logic [31:0] word, input logic [31:0] data);
        check_outputs();
        instr_valid = valid;
        instr = word;
        rs1_data = data;
        instr_count++;
        predict(valid, word, data);
        @(negedge clk);
    endtask

    task automatic random_step();
        int pct;
        int sel;
        logic [31:0] r;
        logic [11:0] addr;
        logic [4:0] src;
        logic [4:0] rd;
        logic [2:0] f3;
        pct = rand_below(100);
        r = next_random();
        sel = rand_below(100);
        // Repeat the last address now and then for back-to-back accesses
        if (sel < 30)
            addr = last_addr;
        else if (sel < 75)
            addr = addr_list[4'(rand_below(14))];
        else if (sel < 88)
            addr = 12'(rand_below(4096));
        else
            addr = {8'hf1, 4'(rand_below(8))};
        src = (rand_below(4) == 0) ? 5'd0 : 5'(rand_below(32));
        rd = (rand_below(10) == 0) ? 5'd0 : 5'(rand_below(32));
        f3 = {1'(rand_below(2)), 2'(rand_below(3) + 1)};
        if (pct < 8)
            issue(1'b0, r, next_random());
        else if (pct < 13)
            issue(1'b1, mret_word, r);
        else if (pct < 15)
            issue(1'b1, 32'h0000_0073, r);
        else if (pct < 17)
            issue(1'b1, {r[31:15], 3'b100, r[11:7], opcode_system}, r);
        else if (pct < 19)
            issue(1'b1, {r[31:7], 7'b0110011}, r);
        else
        begin
            last_addr = addr;
            issue(1'b1, {addr, src, f3, rd, opcode_system}, r);
        end
    endtask

    initial
    begin
        rng_state = 32'd42630;
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        rs1_data = '0;
        addr_list = '{csr_mvendorid, csr_marchid, csr_mimpid, csr_mhartid, csr_mstatus,
                      csr_misa, csr_mie, csr_mtvec, csr_mcounteren, csr_mscratch, csr_mepc,
                      csr_mcause, csr_mtval, csr_mip};
        last_addr = csr_mscratch;
        for (int i = 0; i < 14; i++)
            csr_model[addr_list[4'(i)]] = '0;
        csr_model[csr_mvendorid] = `CSR_MVENDORID_VAL;
        csr_model[csr_marchid] = `CSR_MARCHID_VAL;
        csr_model[csr_mimpid] = `CSR_MIMPID_VAL;
        csr_model[csr_mhartid] = `CSR_MHARTID_VAL;
        csr_model[csr_misa] = `CSR_MISA_VAL;
        csr_model[csr_mtvec] = `CSR_MTVEC_VAL;
        csr_model[csr_mcounteren] = `CSR_MCOUNTEREN_VAL;
        csr_model[csr_mstatus] = 32'h0000_1800;
        {exp_rd_wr_en, exp_illegal, exp_mret, exp_read_ok} = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // Read every CSR after reset
        for (int i = 0; i < 14; i++)
            issue(1'b1, {addr_list[4'(i)], 5'd0, 3'b010, 5'(i + 1), opcode_system}, '0);
        issue(1'b1, {csr_misa, 5'd1, 3'b001, 5'd2, opcode_system}, '1);
        issue(1'b1, {csr_mtvec, 5'd1, 3'b001, 5'd3, opcode_system}, '1);
        issue(1'b1, {csr_mcounteren, 5'd1, 3'b001, 5'd4, opcode_system}, '1);
        repeat (num_random) random_step();
        for (int i = 0; i < 14; i++)
            issue(1'b1, {addr_list[4'(i)], 5'd0, 3'b010, 5'(i + 1), opcode_system}, '0);
        check_outputs();
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== hdl/csr_unit.sv ====
`timescale 1ns/100ps
`include "csr_defines.svh"

module csr_unit (
    input logic clk,
    input logic rst_n,
    input logic instr_valid,
    input logic [31:0] instr,
    input logic [`CSR_XLEN-1:0] rs1_data,
    output logic rd_wr_en,
    output logic [4:0] rd_addr,
    output logic [`CSR_XLEN-1:0] rd_data,
    output logic illegal_instr,
    output logic mret_valid,
    output logic [`CSR_XLEN-1:0] mret_pc
);

    import csr_pkg::*;

    csr_op_t op;
    csr_addr_t csr_addr;
    logic [4:0] dec_rd_addr;
    logic [`CSR_XLEN-1:0] operand;
    logic csr_wr_req;
    logic is_mret;
    logic decode_illegal;
    logic [`CSR_XLEN-1:0] csr_rdata;
    logic [`CSR_XLEN-1:0] csr_wdata;
    logic addr_hit;
    logic [`CSR_XLEN-1:0] mepc;

    csr_decode decode_i (
        .instr_valid(instr_valid),
        .instr(instr),
        .rs1_data(rs1_data),
        .op(op),
        .csr_addr(csr_addr),
        .rd_addr(dec_rd_addr),
        .operand(operand),
        .csr_wr_req(csr_wr_req),
        .is_mret(is_mret),
        .decode_illegal(decode_illegal)
    );

    csr_execute execute_i (
        .op(op),
        .operand(operand),
        .csr_rdata(csr_rdata),
        .csr_wdata(csr_wdata)
    );

    csr_file file_i (
        .clk(clk),
        .rst_n(rst_n),
        .csr_addr(csr_addr),
        .csr_wr_req(csr_wr_req),
        .decode_illegal(decode_illegal),
        .csr_wdata(csr_wdata),
        .is_mret(is_mret),
        .csr_rdata(csr_rdata),
        .addr_hit(addr_hit),
        .mepc(mepc)
    );

    csr_result result_i (
        .clk(clk),
        .rst_n(rst_n),
        .instr_valid(instr_valid),
        .op(op),
        .rd_addr(dec_rd_addr),
        .csr_rdata(csr_rdata),
        .addr_hit(addr_hit),
        .decode_illegal(decode_illegal),
        .is_mret(is_mret),
        .mepc(mepc),
        .rd_wr_en(rd_wr_en),
        .rd_addr_q(rd_addr),
        .rd_data(rd_data),
        .illegal_instr(illegal_instr),
        .mret_valid(mret_valid),
        .mret_pc(mret_pc)
    );

endmodule

// ==== hdl/csr_result.sv ====
`timescale 1ns/100ps
`include "csr_defines.svh"

module csr_result (
    input logic clk,
    input logic rst_n,
    input logic instr_valid,
    input csr_pkg::csr_op_t op,
    input logic [4:0] rd_addr,
    input logic [`CSR_XLEN-1:0] csr_rdata,
    input logic addr_hit,
    input logic decode_illegal,
    input logic is_mret,
    input logic [`CSR_XLEN-1:0] mepc,
    output logic rd_wr_en,
    output logic [4:0] rd_addr_q,
    output logic [`CSR_XLEN-1:0] rd_data,
    output logic illegal_instr,
    output logic mret_valid,
    output logic [`CSR_XLEN-1:0] mret_pc
);

    import csr_pkg::*;

    logic is_csr;
    logic illegal_d;
    logic rd_wr_en_d;

    assign is_csr = instr_valid && (op != csr_op_none);

    // A CSR op to a missing address is illegal too
    assign illegal_d = instr_valid && (decode_illegal || (is_csr && !addr_hit));

    // x0 is never written
    assign rd_wr_en_d = is_csr && addr_hit && !decode_illegal && (rd_addr != 5'd0);

    // Strobes last one cycle
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rd_wr_en <= 1'b0;
            illegal_instr <= 1'b0;
            mret_valid <= 1'b0;
        end
        else
        begin
            rd_wr_en <= rd_wr_en_d;
            illegal_instr <= illegal_d;
            mret_valid <= instr_valid && is_mret;
        end
    end

    // Old CSR value and redirect target
    always_ff @(posedge clk)
    begin
        rd_addr_q <= rd_addr;
        rd_data <= csr_rdata;
        mret_pc <= mepc;
    end

endmodule

// ==== hdl/csr_file.sv ====
`timescale 1ns/100ps
`include "csr_defines.svh"

module csr_file (
    input logic clk,
    input logic rst_n,
    input csr_pkg::csr_addr_t csr_addr,
    input logic csr_wr_req,
    input logic decode_illegal,
    input logic [`CSR_XLEN-1:0] csr_wdata,
    input logic is_mret,
    output logic [`CSR_XLEN-1:0] csr_rdata,
    output logic addr_hit,
    output logic [`CSR_XLEN-1:0] mepc
);

    import csr_pkg::*;

    // Only machine mode exists
    localparam logic [1:0] machine_mode = 2'b11;

    logic wr_en;

    // mstatus fields kept as single bits
    logic mstatus_mie;
    logic mstatus_mpie;
    logic [`CSR_XLEN-1:0] mstatus;

    logic [`CSR_XLEN-1:0] mie_q;
    logic [`CSR_XLEN-1:0] mip_q;
    logic [`CSR_XLEN-1:0] mscratch_q;
    logic [`CSR_XLEN-1:0] mepc_q;
    logic [`CSR_XLEN-1:0] mcause_q;
    logic [`CSR_XLEN-1:0] mtval_q;

    assign wr_en = csr_wr_req && !decode_illegal;

    // MPP at 12:11, MPIE at 7, MIE at 3
    assign mstatus = {{(`CSR_XLEN-13){1'b0}}, machine_mode, 3'b000,
                      mstatus_mpie, 3'b000, mstatus_mie, 3'b000};

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            mstatus_mie <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_q <= '0;
            mip_q <= '0;
            mscratch_q <= '0;
            mepc_q <= '0;
            mcause_q <= '0;
            mtval_q <= '0;
        end
        else if (is_mret)
        begin
            // Pop the interrupt enable stack
            mstatus_mie <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
        end
        else if (wr_en)
        begin
            case (csr_addr)
                csr_mstatus:
                begin
                    mstatus_mie <= csr_wdata[3];
                    mstatus_mpie <= csr_wdata[7];
                end
                csr_mie:
                begin
                    mie_q <= csr_wdata & `CSR_MIE_MASK;
                end
                csr_mip:
                begin
                    mip_q <= csr_wdata & `CSR_MIP_MASK;
                end
                csr_mscratch:
                begin
                    mscratch_q <= csr_wdata;
                end
                csr_mepc:
                begin
                    // IALIGN is 32, low bits stay zero
                    mepc_q <= {csr_wdata[`CSR_XLEN-1:2], 2'b00};
                end
                csr_mcause:
                begin
                    mcause_q <= csr_wdata;
                end
                csr_mtval:
                begin
                    mtval_q <= csr_wdata;
                end
                default:
                begin
                    // misa, mtvec, mcounteren keep their fixed values
                end
            endcase
        end
    end

    // Read selection
    always_comb
    begin
        addr_hit = 1'b1;
        case (csr_addr)
            csr_mvendorid: csr_rdata = `CSR_MVENDORID_VAL;
            csr_marchid: csr_rdata = `CSR_MARCHID_VAL;
            csr_mimpid: csr_rdata = `CSR_MIMPID_VAL;
            csr_mhartid: csr_rdata = `CSR_MHARTID_VAL;
            csr_mstatus: csr_rdata = mstatus;
            csr_misa: csr_rdata = `CSR_MISA_VAL;
            csr_mie: csr_rdata = mie_q;
            csr_mtvec: csr_rdata = `CSR_MTVEC_VAL;
            csr_mcounteren: csr_rdata = `CSR_MCOUNTEREN_VAL;
            csr_mscratch: csr_rdata = mscratch_q;
            csr_mepc: csr_rdata = mepc_q;
            csr_mcause: csr_rdata = mcause_q;
            csr_mtval: csr_rdata = mtval_q;
            csr_mip: csr_rdata = mip_q;
            default:
            begin
                csr_rdata = '0;
                addr_hit = 1'b0;
            end
        endcase
    end

    // Return address for MRET
    assign mepc = mepc_q;

endmodule

// ==== hdl/csr_execute.sv ====
`timescale 1ns/100ps
`include "csr_defines.svh"

module csr_execute (
    input csr_pkg::csr_op_t op,
    input logic [`CSR_XLEN-1:0] operand,
    input logic [`CSR_XLEN-1:0] csr_rdata,
    output logic [`CSR_XLEN-1:0] csr_wdata
);

    import csr_pkg::*;

    // Read-modify-write of the old value
    always_comb
    begin
        case (op)
            csr_op_rw:
            begin
                csr_wdata = operand;
            end
            csr_op_rs:
            begin
                // Set the bits given by the operand
                csr_wdata = csr_rdata | operand;
            end
            csr_op_rc:
            begin
                // Clear the bits given by the operand
                csr_wdata = csr_rdata & ~operand;
            end
            default:
            begin
                // Nothing gets written without an op
                csr_wdata = csr_rdata;
            end
        endcase
    end

endmodule

// ==== hdl/csr_decode.sv ====
`timescale 1ns/100ps
`include "csr_defines.svh"

module csr_decode (
    input logic instr_valid,
    input logic [31:0] instr,
    input logic [`CSR_XLEN-1:0] rs1_data,
    output csr_pkg::csr_op_t op,
    output csr_pkg::csr_addr_t csr_addr,
    output logic [4:0] rd_addr,
    output logic [`CSR_XLEN-1:0] operand,
    output logic csr_wr_req,
    output logic is_mret,
    output logic decode_illegal
);

    import csr_pkg::*;

    localparam logic [6:0] opcode_system = 7'b1110011;
    localparam logic [2:0] f3_priv = 3'b000;
    localparam logic [2:0] f3_reserved = 3'b100;
    localparam logic [31:0] mret_word = 32'h3020_0073;

    logic [2:0] funct3;
    logic [4:0] src_field;
    logic is_system;
    logic csr_form;
    logic ro_space;
    logic unknown_form;

    assign funct3 = instr[14:12];
    // rs1 index for register forms, uimm for immediate forms
    assign src_field = instr[19:15];

    assign is_system = instr[6:0] == opcode_system;
    assign csr_form = is_system && (funct3 != f3_priv) && (funct3 != f3_reserved);

    // Top two address bits set means read-only space
    assign ro_space = instr[31:30] == 2'b11;

    assign csr_addr = csr_addr_t'(instr[31:20]);
    assign rd_addr = instr[11:7];

    // Immediate forms zero-extend the 5-bit uimm
    assign operand = funct3[2] ? {{(`CSR_XLEN-5){1'b0}}, src_field} : rs1_data;

    always_comb
    begin
        op = csr_op_none;
        if (instr_valid && csr_form)
        begin
            case (funct3[1:0])
                2'b01: op = csr_op_rw;
                2'b10: op = csr_op_rs;
                default: op = csr_op_rc;
            endcase
        end
    end

    // RS and RC with a zero source only read
    assign csr_wr_req = (op == csr_op_rw) || ((op != csr_op_none) && (src_field != 5'd0));

    assign is_mret = instr_valid && (instr == mret_word);

    // ECALL, EBREAK and WFI need trap entry, which this unit lacks
    assign unknown_form = is_system &&
        ((funct3 == f3_reserved) || ((funct3 == f3_priv) && (instr != mret_word)));

    assign decode_illegal = instr_valid && (unknown_form || (csr_wr_req && ro_space));

endmodule

// ==== hdl/csr_pkg.sv ====
package csr_pkg;

    // Encoded like funct3[1:0] of the CSR forms
    typedef enum logic [1:0] {
        csr_op_none = 2'b00,
        csr_op_rw = 2'b01,
        csr_op_rs = 2'b10,
        csr_op_rc = 2'b11
    } csr_op_t;

    // Implemented machine-mode CSR addresses
    typedef enum logic [11:0] {
        // Information registers, read-only
        csr_mvendorid = 12'hf11,
        csr_marchid = 12'hf12,
        csr_mimpid = 12'hf13,
        csr_mhartid = 12'hf14,

        // Trap setup
        csr_mstatus = 12'h300,
        csr_misa = 12'h301,
        csr_mie = 12'h304,
        csr_mtvec = 12'h305,
        csr_mcounteren = 12'h306,

        // Trap handling
        csr_mscratch = 12'h340,
        csr_mepc = 12'h341,
        csr_mcause = 12'h342,
        csr_mtval = 12'h343,
        csr_mip = 12'h344
    } csr_addr_t;

endpackage

// ==== include/csr_defines.svh ====
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// Data path width
`define CSR_XLEN 32

// Machine information registers
`define CSR_MVENDORID_VAL 32'h0000_0000
`define CSR_MARCHID_VAL 32'h0000_0000
`define CSR_MIMPID_VAL 32'h0000_0001
`define CSR_MHARTID_VAL 32'h0000_0000

// Fixed trap setup values, writes are dropped
`define CSR_MISA_VAL 32'h4000_0100
`define CSR_MTVEC_VAL 32'h0000_0100
`define CSR_MCOUNTEREN_VAL 32'h0000_0000

// Writable bits of mie: MSIE, MTIE, MEIE
`define CSR_MIE_MASK 32'h0000_0888
// Writable bits of mip: MSIP
`define CSR_MIP_MASK 32'h0000_0008

`endif
